/* Makefile */
TOP := tb_spu_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'Simulation passed'

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir

/* sources.f */
spu_op_pkg.sv
spu_link_pkg.sv
spu_op_delay.sv
spu_op_shift.sv
spu_issue_rx.sv
spu_exec.sv
spu_result_tx.sv
spu_core.sv
tb_spu_core_assert.sv
tb_spu_core.sv

/* spu_core.sv */
`timescale 1ns/10ps

module spu_core
        #(
            parameter   int     LATENCY     = 2 ,   // operator latency, at least 1
            parameter   int     RX_DEPTH    = 4 ,   // input FIFO, sender credits
            parameter   int     TX_DEPTH    = 4 ,   // result FIFO
            parameter   int     OUT_CREDITS = 4     // downstream credits at reset
        )
        (
            input   var logic                           clk         ,
            input   var logic                           rst_n       ,

            input   var spu_link_pkg::spu_in_flit_t     in_flit     ,
            output  var logic                           in_credit   ,

            output  var spu_link_pkg::spu_out_flit_t    out_flit    ,
            input   var logic                           out_credit
        );

    spu_link_pkg::spu_in_flit_t     issue;
    spu_link_pkg::spu_out_flit_t    done;
    logic                           slot_free;

    spu_issue_rx #(.RX_DEPTH(RX_DEPTH)) u_issue_rx (
        .clk        (clk        ),
        .rst_n      (rst_n      ),
        .in_flit    (in_flit    ),
        .in_credit  (in_credit  ),
        .slot_free  (slot_free  ),
        .issue      (issue      )
    );

    spu_exec #(.LATENCY(LATENCY)) u_exec (
        .clk        (clk        ),
        .rst_n      (rst_n      ),
        .issue      (issue      ),
        .done       (done       )
    );

    spu_result_tx
            #(
                .TX_DEPTH       (TX_DEPTH       ),
                .LATENCY        (LATENCY        ),
                .OUT_CREDITS    (OUT_CREDITS    )
            )
        u_result_tx
            (
                .clk            (clk            ),
                .rst_n          (rst_n          ),
                .issue_valid    (issue.valid    ),
                .done           (done           ),
                .slot_free      (slot_free      ),
                .out_flit       (out_flit       ),
                .out_credit     (out_credit     )
            );

endmodule

/* spu_exec.sv */
`timescale 1ns/10ps

module spu_exec
        #(
            parameter   int     LATENCY = 2     // issue to done, at least 1
        )
        (
            input   var logic                           clk     ,
            input   var logic                           rst_n   ,

            input   var spu_link_pkg::spu_in_flit_t     issue   ,
            output  var spu_link_pkg::spu_out_flit_t    done
        );

    localparam int CTRL_BITS = spu_op_pkg::TAG_BITS + 1;

    logic                                   is_shift;
    logic   [spu_op_pkg::DATA_BITS-1:0]     arith_data;
    logic   [spu_op_pkg::DATA_BITS-1:0]     shift_res;
    logic                                   arith_vld;
    logic   [spu_op_pkg::DATA_BITS-1:0]     arith_q;
    logic                                   ctrl_vld;
    logic   [CTRL_BITS-1:0]                 ctrl_q;
    logic                                   sel_q;
    logic   [spu_op_pkg::TAG_BITS-1:0]      tag_q;

    assign is_shift = issue.instr.op inside {spu_op_pkg::OP_SLL, spu_op_pkg::OP_SRL,
                                             spu_op_pkg::OP_SRA};

    always_comb begin
        case (issue.instr.op)
            spu_op_pkg::OP_ADD: arith_data = issue.instr.a + issue.instr.b;
            spu_op_pkg::OP_SUB: arith_data = issue.instr.a - issue.instr.b;
            spu_op_pkg::OP_XOR: arith_data = issue.instr.a ^ issue.instr.b;
            default:            arith_data = '0;
        endcase
    end

    spu_op_shift #(.LATENCY(LATENCY)) u_shift (
        .clk    (clk                            ),
        .rst_n  (rst_n                          ),
        .valid  (issue.valid && is_shift        ),
        .op     (issue.instr.op                 ),
        .data   (issue.instr.a                  ),
        .shift  (issue.instr.b[4:0]             ),  // low 5 bits only
        .result (shift_res                      )
    );

    spu_op_delay #(.LATENCY(LATENCY), .DATA_BITS(spu_op_pkg::DATA_BITS)) u_arith_dly (
        .clk        (clk                        ),
        .rst_n      (rst_n                      ),
        .in_valid   (issue.valid && !is_shift   ),
        .in_data    (arith_data                 ),
        .out_valid  (arith_vld                  ),
        .out_data   (arith_q                    )
    );

    // tag and shift select ride alongside the data
    spu_op_delay #(.LATENCY(LATENCY), .DATA_BITS(CTRL_BITS)) u_ctrl_dly (
        .clk        (clk                        ),
        .rst_n      (rst_n                      ),
        .in_valid   (issue.valid                ),
        .in_data    ({is_shift, issue.instr.tag}),
        .out_valid  (ctrl_vld                   ),
        .out_data   (ctrl_q                     )
    );

    assign {sel_q, tag_q} = ctrl_q;

    always_comb begin
        done.valid       = ctrl_vld;
        done.result.tag  = tag_q;
        done.result.data = sel_q ? shift_res : (arith_vld ? arith_q : '0);
    end

endmodule

/* spu_issue_rx.sv */
`timescale 1ns/10ps

module spu_issue_rx
        #(
            parameter   int     RX_DEPTH    = 4     // entries, same as initial sender credits
        )
        (
            input   var logic                           clk         ,
            input   var logic                           rst_n       ,

            input   var spu_link_pkg::spu_in_flit_t     in_flit     ,
            output  var logic                           in_credit   ,

            input   var logic                           slot_free   ,
            output  var spu_link_pkg::spu_in_flit_t     issue
        );

    localparam int PTR_BITS = (RX_DEPTH > 1) ? $clog2(RX_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(RX_DEPTH + 1);

    spu_op_pkg::spu_instr_t     mem [RX_DEPTH];
    logic   [PTR_BITS-1:0]      wr_ptr;
    logic   [PTR_BITS-1:0]      rd_ptr;
    logic   [CNT_BITS-1:0]      count;
    logic                       push;
    logic                       pop;

    // sender only sends with a credit, so no full check here
    assign push = in_flit.valid;
    assign pop  = (count != '0) && slot_free;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_flit.instr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(RX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(RX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_BITS'(push) - CNT_BITS'(pop);
        end
    end

    always_comb begin
        issue.valid = pop;
        issue.instr = mem[rd_ptr];  // head entry
    end

    assign in_credit = pop;     // one credit back per issued entry

endmodule

/* spu_link_pkg.sv */
package spu_link_pkg;

    localparam int CREDIT_BITS = 4;     // credit counter width on both links

    // instruction flit on the input link
    typedef struct packed {
        logic                       valid;
        spu_op_pkg::spu_instr_t     instr;
    } spu_in_flit_t;

    // result flit on the output link
    typedef struct packed {
        logic                       valid;
        spu_op_pkg::spu_result_t    result;
    } spu_out_flit_t;

endpackage

/* spu_op_delay.sv */
`timescale 1ns/10ps

module spu_op_delay
        #(
            parameter   int     LATENCY     = 1 ,   // number of stages, at least 1
            parameter   int     DATA_BITS   = 8     // payload width
        )
        (
            input   var logic                   clk         ,
            input   var logic                   rst_n       ,

            input   var logic                   in_valid    ,
            input   var logic   [DATA_BITS-1:0] in_data     ,

            output  var logic                   out_valid   ,
            output  var logic   [DATA_BITS-1:0] out_data
        );

    logic   [LATENCY-1:0]                   stage_valid;
    logic   [LATENCY-1:0][DATA_BITS-1:0]    stage_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= '0;
        end else begin
            stage_valid[0] <= in_valid;
            for (int i = 1; i < LATENCY; i++) begin
                stage_valid[i] <= stage_valid[i-1];
            end
        end
    end

    // payload only moves with its valid bit
    always_ff @(posedge clk) begin
        if (in_valid) begin
            stage_data[0] <= in_data;
        end
        for (int i = 1; i < LATENCY; i++) begin
            if (stage_valid[i-1]) begin
                stage_data[i] <= stage_data[i-1];
            end
        end
    end

    assign out_valid = stage_valid[LATENCY-1];
    assign out_data  = stage_data[LATENCY-1];

endmodule

/* spu_op_pkg.sv */
package spu_op_pkg;

    localparam int DATA_BITS = 32;  // operand and result width
    localparam int TAG_BITS  = 4;   // in-order tag carried with each item

    // low three entries are the shift group
    typedef enum logic [2:0] {
        OP_SLL = 3'd0,
        OP_SRL = 3'd1,
        OP_SRA = 3'd2,
        OP_ADD = 3'd3,
        OP_SUB = 3'd4,
        OP_XOR = 3'd5
    } spu_op_e;

    typedef struct packed {
        spu_op_e                op;     // operation select
        logic   [TAG_BITS-1:0]  tag;
        logic   [DATA_BITS-1:0] a;      // first operand, shift source
        logic   [DATA_BITS-1:0] b;      // second operand, shift amount in [4:0]
    } spu_instr_t;

    typedef struct packed {
        logic   [TAG_BITS-1:0]  tag;
        logic   [DATA_BITS-1:0] data;
    } spu_result_t;

endpackage

/* spu_op_shift.sv */
`timescale 1ns/10ps

module spu_op_shift
        #(
            parameter   int     LATENCY = 1     // cycles from valid to result
        )
        (
            input   var logic                               clk     ,
            input   var logic                               rst_n   ,

            input   var logic                               valid   ,
            input   var spu_op_pkg::spu_op_e                op      ,
            input   var logic   [spu_op_pkg::DATA_BITS-1:0] data    ,
            input   var logic   [4:0]                       shift   ,

            output  var logic   [spu_op_pkg::DATA_BITS-1:0] result
        );

    logic   [spu_op_pkg::DATA_BITS-1:0] st0_data;
    logic                               dly_valid;
    logic   [spu_op_pkg::DATA_BITS-1:0] dly_data;

    always_comb begin
        case (op)
            spu_op_pkg::OP_SRL: st0_data = data >> shift;
            spu_op_pkg::OP_SRA: st0_data = $signed(data) >>> shift;    // sign fill
            default:            st0_data = data << shift;
        endcase
    end

    spu_op_delay
            #(
                .LATENCY    (LATENCY                ),
                .DATA_BITS  (spu_op_pkg::DATA_BITS  )
            )
        u_latency
            (
                .clk        (clk        ),
                .rst_n      (rst_n      ),
                .in_valid   (valid      ),
                .in_data    (st0_data   ),
                .out_valid  (dly_valid  ),
                .out_data   (dly_data   )
            );

    assign result = dly_valid ? dly_data : '0;  // zero between results

endmodule

/* spu_result_tx.sv */
`timescale 1ns/10ps

module spu_result_tx
        #(
            parameter   int     TX_DEPTH    = 4 ,   // result FIFO entries
            parameter   int     LATENCY     = 2 ,   // bounds results in flight
            parameter   int     OUT_CREDITS = 4     // downstream credits at reset
        )
        (
            input   var logic                           clk         ,
            input   var logic                           rst_n       ,

            input   var logic                           issue_valid ,
            input   var spu_link_pkg::spu_out_flit_t    done        ,
            output  var logic                           slot_free   ,

            output  var spu_link_pkg::spu_out_flit_t    out_flit    ,
            input   var logic                           out_credit
        );

    localparam int PTR_BITS    = (TX_DEPTH > 1) ? $clog2(TX_DEPTH) : 1;
    localparam int CNT_BITS    = $clog2(TX_DEPTH + 1);
    localparam int FLIGHT_BITS = $clog2(LATENCY + 1);

    spu_op_pkg::spu_result_t                mem [TX_DEPTH];
    logic   [PTR_BITS-1:0]                  wr_ptr;
    logic   [PTR_BITS-1:0]                  rd_ptr;
    logic   [CNT_BITS-1:0]                  count;
    logic   [FLIGHT_BITS-1:0]               in_flight;     // issued, not yet done
    logic   [spu_link_pkg::CREDIT_BITS-1:0] credit_cnt;
    logic                                   push;
    logic                                   pop;

    assign push = done.valid;   // space reserved at issue time
    assign pop  = (count != '0) && (credit_cnt != '0);

    // reserve a slot for everything already in the pipe
    assign slot_free = (int'(count) + int'(in_flight)) < TX_DEPTH;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= done.result;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            in_flight  <= '0;
            credit_cnt <= spu_link_pkg::CREDIT_BITS'(OUT_CREDITS);
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(TX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(TX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count      <= count + CNT_BITS'(push) - CNT_BITS'(pop);
            in_flight  <= in_flight + FLIGHT_BITS'(issue_valid) - FLIGHT_BITS'(done.valid);
            credit_cnt <= credit_cnt + spu_link_pkg::CREDIT_BITS'(out_credit)
                                     - spu_link_pkg::CREDIT_BITS'(pop);
        end
    end

    always_comb begin
        out_flit.valid  = pop;  // one credit spent per flit
        out_flit.result = mem[rd_ptr];
    end

endmodule

/* tb_spu_core.sv */
`timescale 1ns/10ps

module tb_spu_core;

    localparam int LATENCY     = 2;
    localparam int RX_DEPTH    = 4;
    localparam int TX_DEPTH    = 4;
    localparam int OUT_CREDITS = 4;
    localparam int DW          = spu_op_pkg::DATA_BITS;
    localparam int CLK_PERIOD  = 4;
    localparam int TABLE_ROWS  = 14;
    localparam int RAND_ROWS   = 64;
    localparam int ROWS_TOTAL  = 3 * TABLE_ROWS + RAND_ROWS;   // table runs three times
    localparam int MODE_GAP    = 0;     // one item in flight at a time
    localparam int MODE_STREAM = 1;
    localparam int POL_NOW     = 0;     // receiver returns credits at once
    localparam int POL_HOLD    = 1;
    localparam int POL_RAND    = 2;

    typedef struct packed {
        spu_op_pkg::spu_op_e    op;
        logic   [DW-1:0]        a;
        logic   [DW-1:0]        b;
    } row_t;

    localparam row_t STIM [TABLE_ROWS] = '{
        '{spu_op_pkg::OP_SLL, 32'h8000_0001, 32'h0000_0000},   // shift by 0
        '{spu_op_pkg::OP_SLL, 32'h0000_0001, 32'h0000_001f},
        '{spu_op_pkg::OP_SLL, 32'hffff_ffff, 32'hffff_ffe3},   // only b[4:0] counts
        '{spu_op_pkg::OP_SRL, 32'h8000_0000, 32'h0000_001f},
        '{spu_op_pkg::OP_SRL, 32'hdead_beef, 32'h0000_0000},
        '{spu_op_pkg::OP_SRA, 32'h8000_0000, 32'h0000_001f},
        '{spu_op_pkg::OP_SRA, 32'hf000_0000, 32'h0000_0004},
        '{spu_op_pkg::OP_SRA, 32'h7fff_ffff, 32'h0000_001f},
        '{spu_op_pkg::OP_SRA, 32'h8765_4321, 32'h0000_0000},
        '{spu_op_pkg::OP_ADD, 32'hffff_ffff, 32'h0000_0001},   // wraps to zero
        '{spu_op_pkg::OP_ADD, 32'h7fff_ffff, 32'h0000_0001},
        '{spu_op_pkg::OP_SUB, 32'h0000_0000, 32'h0000_0001},
        '{spu_op_pkg::OP_SUB, 32'h8000_0000, 32'h0000_0001},
        '{spu_op_pkg::OP_XOR, 32'ha5a5_a5a5, 32'hffff_ffff}
    };

    logic                               clk;
    logic                               rst_n;
    spu_link_pkg::spu_in_flit_t         in_flit;
    logic                               in_credit;
    spu_link_pkg::spu_out_flit_t        out_flit;
    logic                               out_credit;

    row_t                               row_q [$];
    spu_op_pkg::spu_result_t            exp_q [$];     // expected results in order
    logic   [spu_op_pkg::TAG_BITS-1:0]  next_tag;
    int                                 row_idx;
    int                                 send_credits;  // sender side credit count
    int                                 owed;          // credits the receiver still holds
    int                                 sent;
    int                                 credit_pulses;
    int                                 out_seen;
    int                                 checks;
    int                                 errors;
    int                                 tests;
    int                                 base_err;
    int                                 base_seen;
    int                                 base_pulse;
    int                                 base_sent;

    spu_core
            #(
                .LATENCY        (LATENCY        ),
                .RX_DEPTH       (RX_DEPTH       ),
                .TX_DEPTH       (TX_DEPTH       ),
                .OUT_CREDITS    (OUT_CREDITS    )
            )
        u_spu_core
            (
                .clk            (clk            ),
                .rst_n          (rst_n          ),
                .in_flit        (in_flit        ),
                .in_credit      (in_credit      ),
                .out_flit       (out_flit       ),
                .out_credit     (out_credit     )
            );

    bind spu_core tb_spu_core_assert #(
        .RX_DEPTH       (RX_DEPTH                   ),
        .TX_DEPTH       (TX_DEPTH                   ),
        .OUT_CREDITS    (OUT_CREDITS                )
    ) u_core_assert (
        .clk            (clk                        ),
        .rst_n          (rst_n                      ),
        .out_valid      (out_flit.valid             ),
        .out_credit     (out_credit                 ),
        .credit_cnt     (u_result_tx.credit_cnt     ),
        .issue_valid    (issue.valid                ),
        .in_valid       (in_flit.valid              ),
        .rx_count       (u_issue_rx.count           )
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [DW-1:0] ref_result(input spu_op_pkg::spu_op_e op,
                                                 input logic [DW-1:0] a,
                                                 input logic [DW-1:0] b);
        logic   [4:0]       sh;
        logic   [DW-1:0]    fill;
        sh   = b[4:0];
        fill = (sh == 5'd0) ? '0 : {DW{a[DW-1]}} << (6'd32 - {1'b0, sh});  // sign bits on top
        case (op)
            spu_op_pkg::OP_SLL: return a << sh;
            spu_op_pkg::OP_SRL: return a >> sh;
            spu_op_pkg::OP_SRA: return (a >> sh) | fill;
            spu_op_pkg::OP_ADD: return a + b;
            spu_op_pkg::OP_SUB: return a - b;
            spu_op_pkg::OP_XOR: return a ^ b;
            default:            return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [DW-1:0] got,
                               input logic [DW-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic load_table();
        row_q.delete();
        for (int i = 0; i < TABLE_ROWS; i++) begin
            row_q.push_back(STIM[i]);
        end
    endtask

    task automatic load_random(input int count);
        row_t r;
        row_q.delete();
        for (int i = 0; i < count; i++) begin
            r.op = spu_op_pkg::spu_op_e'(3'($urandom_range(5)));
            r.a  = $urandom();
            r.b  = $urandom();
            row_q.push_back(r);
        end
    endtask

    // one clock of sender and receiver models, all on the falling edge
    task automatic cycle_step(input bit allow_send, input int policy);
        spu_op_pkg::spu_result_t    exp_r;
        logic                       got_credit;
        @(negedge clk);
        got_credit = in_credit;
        if (out_flit.valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("result with tag 0x%h arrived when none was expected",
                         out_flit.result.tag);
            end else begin
                exp_r = exp_q.pop_front();
                check_value("out_flit.result.tag", 32'(out_flit.result.tag), 32'(exp_r.tag));
                check_value("out_flit.result.data", out_flit.result.data, exp_r.data);
            end
            out_seen++;
            owed++;
        end
        out_credit = 1'b0;
        if (owed > 0 &&
                (policy == POL_NOW || (policy == POL_RAND && $urandom_range(3) == 0))) begin
            out_credit = 1'b1;
            owed--;
        end
        in_flit = '0;
        if (allow_send && send_credits > 0 && row_idx < row_q.size()) begin
            in_flit.valid     = 1'b1;
            in_flit.instr.op  = row_q[row_idx].op;
            in_flit.instr.tag = next_tag;
            in_flit.instr.a   = row_q[row_idx].a;
            in_flit.instr.b   = row_q[row_idx].b;
            exp_r.tag  = next_tag;
            exp_r.data = ref_result(row_q[row_idx].op, row_q[row_idx].a, row_q[row_idx].b);
            exp_q.push_back(exp_r);
            next_tag++;
            row_idx++;
            send_credits--;
            sent++;
        end
        if (got_credit) begin   // spendable from the next cycle on
            send_credits++;
            credit_pulses++;
        end
    endtask

    task automatic start_test();
        row_idx    = 0;
        base_err   = errors;
        base_seen  = out_seen;
        base_pulse = credit_pulses;
        base_sent  = sent;
    endtask

    task automatic run_rows(input int mode, input int policy);
        while (row_idx < row_q.size() || exp_q.size() != 0 || owed != 0) begin
            cycle_step(mode == MODE_STREAM || exp_q.size() == 0, policy);
        end
    endtask

    task automatic end_test(input string name);
        check_value("in_credit pulses", 32'(credit_pulses - base_pulse), 32'(sent - base_sent));
        tests++;
        $display("test %s: %0d results, %0d errors", name, out_seen - base_seen,
                 errors - base_err);
    endtask

    initial begin
        void'($urandom(32'h29f4_f226));
        rst_n         = 1'b0;
        in_flit       = '0;
        out_credit    = 1'b0;
        next_tag      = '0;
        send_credits  = RX_DEPTH;
        owed          = 0;
        sent          = 0;
        credit_pulses = 0;
        out_seen      = 0;
        checks        = 0;
        errors        = 0;
        tests         = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        start_test();
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check_value("out_flit.valid", 32'(out_flit.valid), 32'd0);
            check_value("in_credit", 32'(in_credit), 32'd0);
        end
        end_test("idle");

        load_table();
        start_test();
        run_rows(MODE_GAP, POL_NOW);
        end_test("edge");

        load_table();
        start_test();
        run_rows(MODE_STREAM, POL_NOW);
        end_test("stream");

        load_table();
        start_test();
        repeat (60) cycle_step(1'b1, POL_HOLD);
        check_value("out_flit count while held", 32'(out_seen - base_seen), 32'(OUT_CREDITS));
        // both FIFOs full and the sender out of credits
        check_value("flits accepted while held", 32'(sent - base_sent),
                    32'(OUT_CREDITS + TX_DEPTH + RX_DEPTH));
        run_rows(MODE_STREAM, POL_NOW);
        end_test("backpress");

        load_random(RAND_ROWS);
        start_test();
        run_rows(MODE_STREAM, POL_RAND);
        end_test("random");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (ROWS_TOTAL * 20 + 200));
        $display("timeout: tests did not finish within %0d cycles", ROWS_TOTAL * 20 + 200);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* tb_spu_core_assert.sv */
`timescale 1ns/10ps

module tb_spu_core_assert
        #(
            parameter   int     RX_DEPTH    = 4 ,
            parameter   int     TX_DEPTH    = 4 ,
            parameter   int     OUT_CREDITS = 4
        )
        (
            input   var logic                                   clk         ,
            input   var logic                                   rst_n       ,
            input   var logic                                   out_valid   ,
            input   var logic                                   out_credit  ,
            input   var logic   [spu_link_pkg::CREDIT_BITS-1:0] credit_cnt  ,
            input   var logic                                   issue_valid ,
            input   var logic                                   in_valid    ,
            input   var logic   [$clog2(RX_DEPTH+1)-1:0]        rx_count
        );

    int     link_credits;   // credits the output link still holds
    int     reserved;       // issued results not yet sent out

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            link_credits <= OUT_CREDITS;
            reserved     <= 0;
        end else begin
            link_credits <= link_credits + int'(out_credit) - int'(out_valid);
            reserved     <= reserved + int'(issue_valid) - int'(out_valid);
        end
    end

    // a result only leaves with a credit in hand
    a_out_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (link_credits > 0))
        else $error("out_flit.valid with zero output credits");

    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        int'(credit_cnt) <= OUT_CREDITS)
        else $error("output credit counter above its reset value");

    a_issue_slot: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |-> (reserved < TX_DEPTH))   // issue needs a free result slot
        else $error("issue.valid while slot_free is low");

    a_rx_room: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> (int'(rx_count) < RX_DEPTH))
        else $error("in_flit.valid at a full input FIFO");

endmodule
